//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_wr_edge
FILELIST  = wr_edge.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir

//--- beat_store.sv
// ==================================================
// Beat store
// Write data memory indexed by slot and beat
// ==================================================
`default_nettype none
`timescale 1ns/100ps

module beat_store
    import wr_edge_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       wr_en,
    input  wire t_slot_idx  wr_slot,
    input  wire t_beat_num  wr_beat,
    input  wire t_line_data wr_data,
    input  wire t_slot_idx  rd_slot,
    input  wire t_beat_num  rd_beat,
    output t_line_data      rd_data
);

    // One row per slot, one entry per beat of the largest packet
    t_line_data mem [N_SLOTS][MAX_BEATS];

    // Write port
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_slot][wr_beat] <= wr_data;
        end
    end

    // Read port with one cycle of latency
    // A read of the entry being written returns the old contents
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_slot][rd_beat];
    end

endmodule

`default_nettype wire

//--- beat_tracker.sv
// ==================================================
// Beat tracker
// Follows write packet framing and recovers the start header
// ==================================================
`default_nettype none
`timescale 1ns/100ps

module beat_tracker
    import wr_edge_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       beat_valid,
    input  wire logic       beat_is_write,
    input  wire logic       in_sop,
    input  wire t_cl_len    in_cl_len,
    input  wire t_line_addr in_addr,
    output t_beat_num       beat_num,
    output logic            beat_eop,
    output t_cl_len         hdr_cl_len,
    output t_line_addr      hdr_addr
);

    t_pkt_state state;
    t_beat_num  next_beat;
    t_cl_len    sop_cl_len;
    t_line_addr sop_addr;
    logic       write_beat;
    logic       fresh_hdr;

    // Later beats of a write carry don't-care length and address, so those
    // come from the saved start beat. Start beats and fences use their own
    always_comb
    begin
        write_beat = beat_valid && beat_is_write;
        fresh_hdr = in_sop || !beat_is_write;
        if (fresh_hdr)
        begin
            beat_num = '0;
            hdr_cl_len = in_cl_len;
            hdr_addr = in_addr;
        end
        else
        begin
            beat_num = next_beat;
            hdr_cl_len = sop_cl_len;
            hdr_addr = sop_addr;
        end
        // The length code equals the number of the last beat
        beat_eop = write_beat && (beat_num == t_beat_num'(hdr_cl_len));
    end

    // Packet state and next expected beat number
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= PKT_IDLE;
            next_beat <= '0;
        end
        else if (write_beat)
        begin
            if (beat_eop)
            begin
                state <= PKT_IDLE;
                next_beat <= '0;
            end
            else
            begin
                state <= PKT_ACTIVE;
                next_beat <= beat_num + 1'b1;
            end
        end
    end

    // Start-of-packet header, kept for the beats that follow
    always_ff @(posedge clk)
    begin
        if (write_beat && in_sop)
        begin
            sop_cl_len <= in_cl_len;
            sop_addr <= in_addr;
        end
    end

    // ==================================================
    // Packet framing checks
    // ==================================================

    // A new packet must not start while an earlier one is unfinished
    a_sop_when_idle: assert property (@(posedge clk) disable iff (reset)
        (write_beat && in_sop) |-> (state == PKT_IDLE))
        else $error("beat_tracker: start beat inside an open packet");

    // A continuation beat needs an open packet
    a_later_when_active: assert property (@(posedge clk) disable iff (reset)
        (write_beat && !in_sop) |-> (state == PKT_ACTIVE))
        else $error("beat_tracker: later beat without a start beat");

    // Multi-beat packets start at a naturally aligned line address
    a_sop_aligned: assert property (@(posedge clk) disable iff (reset)
        (write_beat && in_sop) |->
            ((in_addr[BEAT_NUM_WIDTH-1:0] & BEAT_NUM_WIDTH'(in_cl_len)) == '0))
        else $error("beat_tracker: unaligned start address 0x%h", in_addr);

endmodule

`default_nettype wire

//--- edge_ctrl.sv
// ==================================================
// Edge control
// Beat classification, request forwarding and almost-full
// ==================================================
`default_nettype none
`timescale 1ns/100ps

module edge_ctrl
    import wr_edge_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       in_valid,
    input  wire t_wr_opcode in_opcode,
    input  wire t_line_data in_data,
    input  wire logic       beat_eop,
    input  wire t_cl_len    hdr_cl_len,
    input  wire t_line_addr hdr_addr,
    input  wire t_slot_idx  alloc_slot,
    input  wire logic       not_free,
    input  wire logic       downstream_almost_full,
    output logic            beat_valid,
    output logic            beat_is_write,
    output logic            alloc,
    output logic            wr_en,
    output logic            out_valid,
    output t_wr_opcode      out_opcode,
    output t_cl_len         out_cl_len,
    output t_line_addr      out_addr,
    output t_slot_idx       out_slot,
    output logic            almost_full
);

    logic write_beat;
    logic fence_beat;

    // ==================================================
    // Beat classification
    // ==================================================

    always_comb
    begin
        beat_valid = in_valid;
        beat_is_write = (in_opcode == OP_WRLINE);
        write_beat = in_valid && beat_is_write;
        fence_beat = in_valid && (in_opcode == OP_FENCE);
        // Every write beat lands in the store at the head slot
        wr_en = write_beat;
        // The slot is taken only once the whole packet is stored
        alloc = write_beat && beat_eop;
    end

    // ==================================================
    // Forwarded request
    // ==================================================

    // One request per write packet, sent on the beat after its last beat,
    // and fences sent one beat later with their own header
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= alloc || fence_beat;
        end
    end

    // Request payload. The slot number stands in for the write data
    always_ff @(posedge clk)
    begin
        out_opcode <= in_opcode;
        out_cl_len <= hdr_cl_len;
        out_addr <= hdr_addr;
        out_slot <= alloc_slot;
    end

    // Almost-full toward the requester, one cycle behind its sources.
    // Held high in reset so nothing is sent before the edge is ready
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            almost_full <= 1'b1;
        end
        else
        begin
            almost_full <= downstream_almost_full || not_free;
        end
    end

    // Data written into the store must be defined, since downstream
    // only sees it later through the read port
    a_wr_data_known: assert property (@(posedge clk) disable iff (reset)
        write_beat |-> !$isunknown(in_data))
        else $error("edge_ctrl: write beat with unknown data");

endmodule

`default_nettype wire

//--- slot_alloc.sv
// ==================================================
// Slot allocator
// Circular free list of data slots with a reserve
// ==================================================
`default_nettype none
`timescale 1ns/100ps

module slot_alloc
    import wr_edge_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      alloc,
    output t_slot_idx      alloc_slot,
    output logic           not_free,
    input  wire logic      free_valid,
    input  wire t_slot_idx free_slot
);

    t_slot_idx free_list [N_SLOTS];
    // Head and tail wrap on their own because N_SLOTS is a power of two
    t_slot_idx head;
    t_slot_idx tail;
    logic [COUNT_WIDTH-1:0] free_count;
    logic [COUNT_WIDTH-1:0] next_count;

    // The next slot handed out is always the one at the head
    assign alloc_slot = free_list[head];

    always_comb
    begin
        next_count = free_count;
        if (alloc && !free_valid)
        begin
            next_count = free_count - 1'b1;
        end
        else if (free_valid && !alloc)
        begin
            next_count = free_count + 1'b1;
        end
    end

    // List contents. Reset loads every slot in ascending order
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < N_SLOTS; i++)
            begin
                free_list[i] <= t_slot_idx'(i);
            end
        end
        else if (free_valid)
        begin
            free_list[tail] <= free_slot;
        end
    end

    // Pointers, count and the reserve flag
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head <= '0;
            tail <= '0;
            free_count <= COUNT_WIDTH'(N_SLOTS);
            not_free <= 1'b0;
        end
        else
        begin
            if (alloc)
            begin
                head <= head + 1'b1;
            end
            if (free_valid)
            begin
                tail <= tail + 1'b1;
            end
            free_count <= next_count;
            not_free <= (next_count < COUNT_WIDTH'(MIN_FREE_SLOTS));
        end
    end

    // The reserve must keep the requester from draining the list
    a_no_alloc_empty: assert property (@(posedge clk) disable iff (reset)
        alloc |-> (free_count != '0))
        else $error("slot_alloc: allocation from an empty free list");

    // Downstream may only return slots that were handed out
    a_no_free_full: assert property (@(posedge clk) disable iff (reset)
        free_valid |-> (free_count != COUNT_WIDTH'(N_SLOTS)))
        else $error("slot_alloc: slot %0d returned to a full list", free_slot);

endmodule

`default_nettype wire

//--- tb_wr_edge.sv
// ==================================================
// Write request edge testbench
// Drives packets, fences and slot returns, checks requests and data
// ==================================================
`default_nettype none
`timescale 1ns/100ps

module tb_wr_edge
    import wr_edge_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    // All six tests together take about this many clock cycles
    localparam int STIM_CYCLES = 200;
    // Free slots below which the edge raises almost-full
    localparam int RESERVE_SLOTS = 7;

    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    t_wr_opcode in_opcode;
    logic       in_sop;
    t_cl_len    in_cl_len;
    t_line_addr in_addr;
    t_line_data in_data;
    logic       almost_full;
    logic       downstream_almost_full;
    logic       out_valid;
    t_wr_opcode out_opcode;
    t_cl_len    out_cl_len;
    t_line_addr out_addr;
    t_slot_idx  out_slot;
    t_slot_idx  rd_slot;
    t_beat_num  rd_beat;
    t_line_data rd_data;
    logic       free_valid;
    t_slot_idx  free_slot;

    // Reference model state holds the free list order, the slots held downstream
    // and the data per slot and beat
    t_slot_idx  model_free [$];
    t_slot_idx  held_slots [$];
    t_line_data sent_data [N_SLOTS][MAX_BEATS];

    // Expected requests in send order with the cycle each one is due in
    logic [39:0] exp_req_q [$];
    int          exp_due_q [$];
    int seen_count = 0;
    int cycle = 0;

    // Stimulus side and compare side keep their own counters
    int err_count = 0;
    int check_count = 0;
    int cmp_errs = 0;
    int cmp_checks = 0;
    int test_count = 0;
    int test_errs = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    wr_edge_top i_dut (.*);

    // ==================================================
    // Reference model
    // ==================================================

    // Expected request as {uses_slot, opcode, cl_len, addr, slot}.
    // A write gets the slot at the head of the free list, a fence gets none
    function automatic logic [39:0] ref_request(input t_wr_opcode op, input t_cl_len len,
                                                input t_line_addr addr);
        logic      uses_slot;
        t_slot_idx slot;
        uses_slot = (op == OP_WRLINE);
        slot = uses_slot ? model_free[0] : '0;
        return {uses_slot, op, len, addr, slot};
    endfunction

    // Multi-beat packets start on a line address aligned to their length
    function automatic t_line_addr aligned_addr(input t_cl_len len);
        return t_line_addr'($urandom) & ~t_line_addr'(len);
    endfunction

    // ==================================================
    // Helper tasks
    // ==================================================

    task automatic report_error(input string msg);
        err_count++;
        $display("%s", msg);
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count + cmp_errs == test_errs)
        begin
            $display("test %0d %s: ok", test_count, name);
        end
        else
        begin
            $display("test %0d %s: %0d errors", test_count, name,
                     err_count + cmp_errs - test_errs);
        end
        test_errs = err_count + cmp_errs;
    endtask

    // Sends one write packet; later beats get random don't-care header fields
    task automatic send_write(input t_cl_len len, input t_line_addr addr);
        int         n;
        t_slot_idx  slot;
        t_line_data d;
        n = int'(len) + 1;
        slot = model_free[0];
        for (int b = 0; b < n; b++)
        begin
            @(posedge clk);
            d = {$urandom, $urandom};
            sent_data[slot][b] = d;
            in_valid <= 1'b1;
            in_opcode <= OP_WRLINE;
            in_data <= d;
            in_sop <= (b == 0);
            in_cl_len <= (b == 0) ? len : t_cl_len'(2'($urandom_range(3, 0)));
            in_addr <= (b == 0) ? addr : t_line_addr'($urandom);
        end
        // The request follows the last beat by one cycle
        exp_req_q.push_back(ref_request(OP_WRLINE, len, addr));
        exp_due_q.push_back(cycle + 2);
        void'(model_free.pop_front());
        held_slots.push_back(slot);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic send_fence(input t_line_addr addr);
        @(posedge clk);
        in_valid <= 1'b1;
        in_opcode <= OP_FENCE;
        in_sop <= 1'b1;
        in_cl_len <= CL_LEN_1;
        in_addr <= addr;
        in_data <= {$urandom, $urandom};
        exp_req_q.push_back(ref_request(OP_FENCE, CL_LEN_1, addr));
        exp_due_q.push_back(cycle + 2);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // Returned slots join the free list at its tail
    task automatic return_slot(input t_slot_idx slot);
        @(posedge clk);
        free_valid <= 1'b1;
        free_slot <= slot;
        model_free.push_back(slot);
        @(posedge clk);
        free_valid <= 1'b0;
    endtask

    // Waits until every expected request was seen, then lets status settle
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (seen_count < exp_req_q.size() && waited < 16)
        begin
            @(posedge clk);
            waited++;
        end
        if (seen_count < exp_req_q.size())
        begin
            report_error("Expected requests still missing after 16 cycles");
        end
        repeat (2) @(posedge clk);
    endtask

    // Read data comes back one cycle after the address is taken
    task automatic read_check(input t_slot_idx slot, input t_beat_num beat);
        @(posedge clk);
        rd_slot <= slot;
        rd_beat <= beat;
        repeat (2) @(posedge clk);
        check_count++;
        if (rd_data !== sent_data[slot][beat])
        begin
            report_error($sformatf("CHECK FAILED rd_data: got 0x%h, expected 0x%h (slot %0d)",
                                   rd_data, sent_data[slot][beat], slot));
        end
    endtask

    task automatic check_almost_full(input logic exp);
        check_count++;
        if (almost_full !== exp)
        begin
            report_error($sformatf("CHECK FAILED almost_full: got 0x%h, expected 0x%h",
                                   almost_full, exp));
        end
    endtask

    // ==================================================
    // Request compare
    // ==================================================

    always @(posedge clk)
    begin : compare_requests
        logic [39:0] e;
        int          errs;
        errs = 0;
        cycle <= cycle + 1;
        if (out_valid === 1'b1)
        begin
            cmp_checks <= cmp_checks + 1;
            if (seen_count >= exp_req_q.size())
            begin
                errs++;
                $display("Request sent downstream in cycle %0d with none expected", cycle);
            end
            else
            begin
                e = exp_req_q[seen_count];
                if (exp_due_q[seen_count] != cycle)
                begin
                    errs++;
                    $display("Request arrived in cycle %0d, expected in cycle %0d",
                             cycle, exp_due_q[seen_count]);
                end
                if (out_opcode !== e[38])
                begin
                    errs++;
                    $display("CHECK FAILED out_opcode: got 0x%h, expected 0x%h",
                             out_opcode, e[38]);
                end
                if (out_cl_len !== e[37:36])
                begin
                    errs++;
                    $display("CHECK FAILED out_cl_len: got 0x%h, expected 0x%h",
                             out_cl_len, e[37:36]);
                end
                if (out_addr !== e[35:4])
                begin
                    errs++;
                    $display("CHECK FAILED out_addr: got 0x%h, expected 0x%h",
                             out_addr, e[35:4]);
                end
                // Fences carry no slot
                if (e[39] && out_slot !== e[3:0])
                begin
                    errs++;
                    $display("CHECK FAILED out_slot: got 0x%h, expected 0x%h",
                             out_slot, e[3:0]);
                end
                seen_count <= seen_count + 1;
            end
        end
        else if (seen_count < exp_due_q.size() && exp_due_q[seen_count] <= cycle)
        begin
            errs++;
            $display("Request due in cycle %0d never appeared", exp_due_q[seen_count]);
            seen_count <= seen_count + 1;
        end
        cmp_errs <= cmp_errs + errs;
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial
    begin : stimulus
        t_slot_idx pkt_slots [$];
        t_cl_len   pkt_lens [$];
        t_slot_idx order [$];
        t_slot_idx tmp;
        int        j;
        void'($urandom(32'ha5380b26));
        reset <= 1'b1;
        in_valid <= 1'b0;
        in_opcode <= OP_WRLINE;
        in_sop <= 1'b0;
        in_cl_len <= CL_LEN_1;
        in_addr <= '0;
        in_data <= '0;
        downstream_almost_full <= 1'b0;
        rd_slot <= '0;
        rd_beat <= '0;
        free_valid <= 1'b0;
        free_slot <= '0;
        for (int i = 0; i < N_SLOTS; i++)
        begin
            model_free.push_back(t_slot_idx'(i));
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Almost-full stays high for the first cycle out of reset
        @(posedge clk);
        check_count++;
        if (out_valid !== 1'b0)
        begin
            report_error($sformatf("CHECK FAILED out_valid: got 0x%h, expected 0x0", out_valid));
        end
        check_almost_full(1'b1);
        @(posedge clk);
        check_almost_full(1'b0);
        end_test("reset");

        // Single-beat writes take slots 0, 1 and 2
        for (int i = 0; i < 3; i++)
        begin
            pkt_slots.push_back(model_free[0]);
            send_write(CL_LEN_1, t_line_addr'($urandom));
        end
        wait_drain();
        foreach (pkt_slots[i])
        begin
            read_check(pkt_slots[i], '0);
        end
        end_test("single-beat writes");

        // Two- and four-beat packets of random length
        pkt_slots.delete();
        for (int i = 0; i < 4; i++)
        begin
            pkt_lens.push_back(($urandom_range(1, 0) == 1) ? CL_LEN_4 : CL_LEN_2);
            pkt_slots.push_back(model_free[0]);
            send_write(pkt_lens[i], aligned_addr(pkt_lens[i]));
        end
        wait_drain();
        foreach (pkt_slots[i])
        begin
            for (int b = 0; b <= int'(pkt_lens[i]); b++)
            begin
                read_check(pkt_slots[i], t_beat_num'(b));
            end
        end
        end_test("multi-beat packets");

        // A fence between writes takes no slot
        send_write(CL_LEN_2, aligned_addr(CL_LEN_2));
        send_fence(t_line_addr'($urandom));
        send_write(CL_LEN_1, t_line_addr'($urandom));
        wait_drain();
        end_test("fence ordering");

        // Drain the free list below the reserve, then return every held slot
        check_almost_full(1'b0);
        while (model_free.size() >= RESERVE_SLOTS)
        begin
            send_write(CL_LEN_1, t_line_addr'($urandom));
            wait_drain();
        end
        check_almost_full(1'b1);
        order = held_slots;
        held_slots.delete();
        for (int i = order.size() - 1; i > 0; i--)
        begin
            j = $urandom_range(i, 0);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        foreach (order[i])
        begin
            return_slot(order[i]);
        end
        repeat (2) @(posedge clk);
        check_almost_full(1'b0);
        // These run past the old list into the returned slots
        for (int i = 0; i < 8; i++)
        begin
            send_write(CL_LEN_1, t_line_addr'($urandom));
        end
        wait_drain();
        check_almost_full(1'b0);
        end_test("slot exhaustion and reuse");

        // Downstream almost-full reaches the requester one cycle later
        @(posedge clk);
        downstream_almost_full <= 1'b1;
        @(posedge clk);
        check_almost_full(1'b0);
        @(posedge clk);
        check_almost_full(1'b1);
        downstream_almost_full <= 1'b0;
        @(posedge clk);
        check_almost_full(1'b1);
        @(posedge clk);
        check_almost_full(1'b0);
        // Step past the edge so the request compare has counted this cycle
        @(negedge clk);
        end_test("downstream almost-full");

        $display("tests %0d, checks %0d, errors %0d", test_count,
                 check_count + cmp_checks, err_count + cmp_errs);
        if (err_count + cmp_errs == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial
    begin : watchdog
        #(20 * STIM_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish",
                 20 * STIM_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- wr_edge.f
wr_edge_pkg.sv
beat_tracker.sv
slot_alloc.sv
beat_store.sv
edge_ctrl.sv
wr_edge_top.sv
tb_wr_edge.sv

//--- wr_edge_pkg.sv
// ==================================================
// Write request edge package
// Sizes, limits and shared types of the write edge
// ==================================================
`default_nettype none

package wr_edge_pkg;

    // ==================================================
    // Sizes and limits
    // ==================================================

    localparam int DATA_WIDTH = 64;
    localparam int ADDR_WIDTH = 32;
    localparam int N_SLOTS = 16;
    localparam int MAX_BEATS = 4;

    // Beats the requester may still send once almost_full is raised
    localparam int ALM_FULL_THRESHOLD = 2;

    // Keep room for the requester's late beats plus one whole packet, since
    // almost_full may rise while a packet is only partly sent
    localparam int MIN_FREE_SLOTS = ALM_FULL_THRESHOLD + MAX_BEATS + 1;

    localparam int SLOT_IDX_WIDTH = $clog2(N_SLOTS);
    localparam int BEAT_NUM_WIDTH = $clog2(MAX_BEATS);
    // The free count must be able to hold N_SLOTS itself
    localparam int COUNT_WIDTH = $clog2(N_SLOTS + 1);

    // ==================================================
    // Types
    // ==================================================

    typedef logic [DATA_WIDTH-1:0] t_line_data;
    typedef logic [ADDR_WIDTH-1:0] t_line_addr;
    typedef logic [SLOT_IDX_WIDTH-1:0] t_slot_idx;
    typedef logic [BEAT_NUM_WIDTH-1:0] t_beat_num;

    // The length code doubles as the alignment mask and as the last beat number
    typedef enum logic [1:0] {
        CL_LEN_1 = 2'd0,
        CL_LEN_2 = 2'd1,
        CL_LEN_4 = 2'd3
    } t_cl_len;

    typedef enum logic {
        OP_WRLINE = 1'b0,
        OP_FENCE  = 1'b1
    } t_wr_opcode;

    typedef enum logic {
        PKT_IDLE   = 1'b0,
        PKT_ACTIVE = 1'b1
    } t_pkt_state;

endpackage

`default_nettype wire

//--- wr_edge_top.sv
// ==================================================
// Write request edge
// Control plus tracker, slot allocator and data store
// ==================================================
`default_nettype none
`timescale 1ns/100ps

module wr_edge_top
    import wr_edge_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    // Request in
    input  wire logic       in_valid,
    input  wire t_wr_opcode in_opcode,
    input  wire logic       in_sop,
    input  wire t_cl_len    in_cl_len,
    input  wire t_line_addr in_addr,
    input  wire t_line_data in_data,
    output logic            almost_full,
    // Request out
    input  wire logic       downstream_almost_full,
    output logic            out_valid,
    output t_wr_opcode      out_opcode,
    output t_cl_len         out_cl_len,
    output t_line_addr      out_addr,
    output t_slot_idx       out_slot,
    // Read-back
    input  wire t_slot_idx  rd_slot,
    input  wire t_beat_num  rd_beat,
    output t_line_data      rd_data,
    // Slot return
    input  wire logic       free_valid,
    input  wire t_slot_idx  free_slot
);

    logic       beat_valid;
    logic       beat_is_write;
    logic       beat_eop;
    t_beat_num  beat_num;
    t_cl_len    hdr_cl_len;
    t_line_addr hdr_addr;
    logic       alloc;
    t_slot_idx  alloc_slot;
    logic       not_free;
    logic       wr_en;

    edge_ctrl u_ctrl (
        .clk                    (clk),
        .reset                  (reset),
        .in_valid               (in_valid),
        .in_opcode              (in_opcode),
        .in_data                (in_data),
        .beat_eop               (beat_eop),
        .hdr_cl_len             (hdr_cl_len),
        .hdr_addr               (hdr_addr),
        .alloc_slot             (alloc_slot),
        .not_free               (not_free),
        .downstream_almost_full (downstream_almost_full),
        .beat_valid             (beat_valid),
        .beat_is_write          (beat_is_write),
        .alloc                  (alloc),
        .wr_en                  (wr_en),
        .out_valid              (out_valid),
        .out_opcode             (out_opcode),
        .out_cl_len             (out_cl_len),
        .out_addr               (out_addr),
        .out_slot               (out_slot),
        .almost_full            (almost_full)
    );

    beat_tracker u_tracker (
        .clk           (clk),
        .reset         (reset),
        .beat_valid    (beat_valid),
        .beat_is_write (beat_is_write),
        .in_sop        (in_sop),
        .in_cl_len     (in_cl_len),
        .in_addr       (in_addr),
        .beat_num      (beat_num),
        .beat_eop      (beat_eop),
        .hdr_cl_len    (hdr_cl_len),
        .hdr_addr      (hdr_addr)
    );

    slot_alloc u_alloc (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_slot (alloc_slot),
        .not_free   (not_free),
        .free_valid (free_valid),
        .free_slot  (free_slot)
    );

    // All beats of a packet go to the head slot, which is popped at the end
    beat_store u_store (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_slot (alloc_slot),
        .wr_beat (beat_num),
        .wr_data (in_data),
        .rd_slot (rd_slot),
        .rd_beat (rd_beat),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire
